// File: mmuPkg.sv
/*
 * MMU access-check definitions
 * Page access-mode layout, keyring ids, the registered request,
 * keyring modes and the exception codes raised by the checker.
 */
package mmuPkg;

	localparam int numKeySlots = 4;	// Keyring entries in the keyring register

	// Owner or keyring user/group id
	typedef struct packed {
		logic [5:0] group;	// Upper part
		logic [9:0] user;
	} vugidT;

	// Keyring mode, encodings 4 to 7 act as krDenyAll
	typedef enum logic [2:0] {
		krLocked      = 3'd0,
		krFlags       = 3'd1,
		krDenyAll     = 3'd2,
		krFlagsStrict = 3'd3
	} krModeE;

	// TLB access-mode word, flag triplets are {execute, write, read}
	typedef struct packed {
		vugidT      owner;	// Page owner id
		logic [2:0] otherFl;
		logic [2:0] groupFl;
		logic [2:0] userFl;
		krModeE     krMode;
		logic       noUser;	// Base deny bits
		logic       noExec;
		logic       noWrite;
		logic       noRead;
	} accModeT;

	typedef enum logic [15:0] {
		excNone       = 16'h0000,
		excReadFault  = 16'h8001,
		excWriteFault = 16'h8002,
		excKeyDeny    = 16'hA002
	} excCodeE;

	// Request fields after the input register
	typedef struct packed {
		accModeT accMode;
		logic    isWrite;
		logic    isRead;
		logic    supervisor;
	} checkReqT;

	typedef struct packed {
		logic grpEq;
		logic usrEq;
	} slotMatchT;

endpackage

// File: keyringSlotMatch.sv
/*
 * Keyring slot matcher
 * Compares one keyring id with the page owner. An all-zero
 * keyring entry is an empty slot and never matches.
 */
`timescale 1ns/1ps

module keyringSlotMatch
	import mmuPkg::*;
(
	input  vugidT     keyId,
	input  vugidT     owner,
	output slotMatchT match
);

	logic slotUsed;
	logic grpSame;
	logic usrSame;

	assign slotUsed = (keyId != '0);	// Empty slot
	assign grpSame  = (keyId.group == owner.group);
	assign usrSame  = (keyId.user == owner.user);

	// User equality alone is reported; the rule stage pairs it with the group
	assign match.grpEq = slotUsed && grpSame;
	assign match.usrEq = slotUsed && usrSame;

endmodule

// File: accessRequestStage.sv
/*
 * Access request stage
 * Decodes the operation and status fields, registers the whole
 * request with its strobe and splits the keyring into slot ids.
 */
`timescale 1ns/1ps

module accessRequestStage
	import mmuPkg::*;
#(
	parameter int numKeySlots = mmuPkg::numKeySlots
) (
	input  logic                        clock,
	input  logic                        arstN,
	input  logic                        reqValid,
	input  accModeT                     tlbAcc,
	input  logic [16*numKeySlots-1:0]   keyring,
	input  logic [4:0]                  opm,
	input  logic [63:0]                 statusReg,
	output checkReqT                    reqQ,
	output logic                        reqValidQ,
	output vugidT [numKeySlots-1:0]     keyIds
);

	checkReqT                  reqD;
	logic [16*numKeySlots-1:0] keyringQ;

	always_comb begin
		reqD.accMode    = tlbAcc;
		reqD.isWrite    = opm[4];	// Store type
		reqD.isRead     = opm[3];	// Load type
		reqD.supervisor = statusReg[30];
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			reqValidQ <= 1'b0;
		end else begin
			reqValidQ <= reqValid;
		end
	end

	// Payload only moves with a request
	always_ff @(posedge clock) begin
		if (reqValid) begin
			reqQ     <= reqD;
			keyringQ <= keyring;
		end
	end

	// Slot i sits in bits 16*i upward
	always_comb begin
		for (int i = 0; i < numKeySlots; i++) begin
			keyIds[i] = keyringQ[16*i +: 16];
		end
	end

endmodule

// File: accessRuleEval.sv
/*
 * Access rule evaluation
 * Reduces the slot matches to user and group hits, picks the rwx
 * class, applies the keyring mode and then the base deny bits, and
 * registers the resulting exception code.
 */
`timescale 1ns/1ps

module accessRuleEval
	import mmuPkg::*;
#(
	parameter int numKeySlots = mmuPkg::numKeySlots
) (
	input  logic                        clock,
	input  logic                        arstN,
	input  checkReqT                    reqQ,
	input  logic                        reqValidQ,
	input  slotMatchT [numKeySlots-1:0] slotMatch,
	input  vugidT                       keyId0,
	output logic                        excValid,
	output excCodeE                     excCode
);

	logic       grpHit;
	logic       usrHit;
	logic [2:0] classFl;	// {execute, write, read}
	logic       keyringOn;
	logic       usDeny;
	excCodeE    excNext;

	always_comb begin
		grpHit = 1'b0;
		usrHit = 1'b0;
		for (int i = 0; i < numKeySlots; i++) begin
			grpHit = grpHit | slotMatch[i].grpEq;
			// User id only counts inside the same group
			usrHit = usrHit | (slotMatch[i].grpEq & slotMatch[i].usrEq);
		end
	end

	always_comb begin
		if (usrHit)
			classFl = reqQ.accMode.userFl;
		else if (grpHit)
			classFl = reqQ.accMode.groupFl;
		else
			classFl = reqQ.accMode.otherFl;
	end

	assign keyringOn = (keyId0 != '0);	// Keyring disabled when slot 0 empty
	assign usDeny    = reqQ.accMode.noUser && !reqQ.supervisor;

	always_comb begin
		excNext = excNone;

		if (keyringOn) begin
			case (reqQ.accMode.krMode)
				krLocked: begin
					if (reqQ.isWrite)
						excNext = excWriteFault;
					if (reqQ.isRead)
						excNext = excReadFault;
				end
				krFlags: begin
					if (reqQ.isWrite && !classFl[1])
						excNext = excWriteFault;
					if (reqQ.isRead && !classFl[0])
						excNext = excReadFault;
				end
				krFlagsStrict: begin
					if ((reqQ.isWrite && !classFl[1]) || (reqQ.isRead && !classFl[0]))
						excNext = excKeyDeny;
				end
				krDenyAll: excNext = excKeyDeny;
				default:   excNext = excKeyDeny;	// Unnamed modes 4 to 7
			endcase
		end

		// Base deny bits override, read checked last so it wins
		if (reqQ.isWrite && (reqQ.accMode.noWrite || usDeny))
			excNext = excWriteFault;
		if (reqQ.isRead && (reqQ.accMode.noRead || usDeny))
			excNext = excReadFault;
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			excValid <= 1'b0;
			excCode  <= excNone;
		end else begin
			excValid <= reqValidQ;
			if (reqValidQ)
				excCode <= excNext;	// Held between results
		end
	end

endmodule

// File: mmuAccessCheck.sv
/*
 * MMU page access checker
 * Two-cycle pipeline: request register, keyring slot matchers and
 * the rule stage that produces the exception code.
 */
`timescale 1ns/1ps

module mmuAccessCheck
	import mmuPkg::*;
#(
	parameter int numKeySlots = mmuPkg::numKeySlots
) (
	input  logic                      clock,
	input  logic                      arstN,
	input  logic                      reqValid,
	input  accModeT                   tlbAcc,
	input  logic [16*numKeySlots-1:0] keyring,
	input  logic [4:0]                opm,
	input  logic [63:0]               statusReg,
	output logic                      excValid,
	output excCodeE                   excCode
);

	checkReqT                    reqQ;
	logic                        reqValidQ;
	vugidT [numKeySlots-1:0]     keyIds;
	slotMatchT [numKeySlots-1:0] slotMatch;

	accessRequestStage #(
		.numKeySlots(numKeySlots)
	) uReqStage (
		.clock     (clock),
		.arstN     (arstN),
		.reqValid  (reqValid),
		.tlbAcc    (tlbAcc),
		.keyring   (keyring),
		.opm       (opm),
		.statusReg (statusReg),
		.reqQ      (reqQ),
		.reqValidQ (reqValidQ),
		.keyIds    (keyIds)
	);

	for (genvar i = 0; i < numKeySlots; i++) begin : genSlot
		keyringSlotMatch uSlotMatch (
			.keyId (keyIds[i]),
			.owner (reqQ.accMode.owner),
			.match (slotMatch[i])
		);
	end

	accessRuleEval #(
		.numKeySlots(numKeySlots)
	) uRuleEval (
		.clock     (clock),
		.arstN     (arstN),
		.reqQ      (reqQ),
		.reqValidQ (reqValidQ),
		.slotMatch (slotMatch),
		.keyId0    (keyIds[0]),
		.excValid  (excValid),
		.excCode   (excCode)
	);

endmodule

// File: mmuAccessCheck_properties.sv
/*
 * Access checker properties
 * Result strobe timing, reset state and legal exception codes.
 */
`timescale 1ns/1ps

module mmuAccessCheck_properties
	import mmuPkg::*;
(
	input logic    clock,
	input logic    arstN,
	input logic    reqValid,
	input logic    excValid,
	input excCodeE excCode
);

	int assertFails = 0;	// Polled by the testbench at the end

	latencyA: assert property (@(posedge clock) disable iff (!arstN)
		excValid == $past(reqValid, 2))
	else begin
		$error("excValid does not follow reqValid by two cycles");
		assertFails++;
	end

	resetA: assert property (@(posedge clock) !arstN |-> !excValid)
	else begin
		$error("excValid high during reset");
		assertFails++;
	end

	legalCodeA: assert property (@(posedge clock)
		excCode inside {excNone, excReadFault, excWriteFault, excKeyDeny})
	else begin
		$error("illegal exception code %h", excCode);
		assertFails++;
	end

endmodule

bind mmuAccessCheck mmuAccessCheck_properties uProps (
	.clock    (clock),
	.arstN    (arstN),
	.reqValid (reqValid),
	.excValid (excValid),
	.excCode  (excCode)
);

// File: tbMmuAccessCheck.sv
/*
 * Testbench for the MMU page access checker
 * Applies a directed table, then seeded random requests, and checks
 * every exception code and its latency against a reference model.
 */
`timescale 1ns/1ps

module tbMmuAccessCheck
	import mmuPkg::*;
();

	localparam logic [4:0]  opNone  = 5'b00000;
	localparam logic [4:0]  opW     = 5'b10000;
	localparam logic [4:0]  opR     = 5'b01000;
	localparam logic [4:0]  opRW    = 5'b11000;
	localparam logic [63:0] stUser  = 64'h0;
	localparam logic [63:0] stSuper = 64'h4000_0000;	// Supervisor bit 30
	localparam vugidT ownerId = {6'h05, 10'h123};
	localparam vugidT grpId   = {6'h05, 10'h001};	// Same group, other user
	localparam vugidT otherId = {6'h09, 10'h002};
	localparam vugidT swapId  = {6'h09, 10'h123};	// Owner user id, wrong group
	localparam int    numRandom     = 200;
	localparam int    driveToResult = 3;	// Drive edge, sample edge, result edge

	typedef struct packed {
		accModeT     acc;
		logic [63:0] ring;
		logic [4:0]  op;
		logic [63:0] st;
		excCodeE     exp;
	} vecT;

	logic        clock = 1'b0;
	logic        arstN;
	logic        reqValid;
	accModeT     tlbAcc;
	logic [63:0] keyring;
	logic [4:0]  opm;
	logic [63:0] statusReg;
	logic        excValid;
	excCodeE     excCode;

	vecT         vecTable[$];
	excCodeE     expCodes[$];
	int unsigned expEdges[$];
	int unsigned edgeCount = 0;
	int          checked = 0;

	mmuAccessCheck #(.numKeySlots(numKeySlots)) u_dut (
		.clock(clock), .arstN(arstN), .reqValid(reqValid), .tlbAcc(tlbAcc),
		.keyring(keyring), .opm(opm), .statusReg(statusReg),
		.excValid(excValid), .excCode(excCode)
	);

	initial begin
		forever #50 clock = ~clock;
	end

	always @(posedge clock) edgeCount <= edgeCount + 1;

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "stopping at first error");
		end
	endtask

	function automatic accModeT mkAcc(vugidT owner, logic [2:0] oFl, logic [2:0] gFl,
			logic [2:0] uFl, krModeE mode, logic noU, logic noW, logic noR);
		accModeT a;
		a = '0;
		a.owner = owner;
		a.otherFl = oFl;
		a.groupFl = gFl;
		a.userFl = uFl;
		a.krMode = mode;
		a.noUser = noU;
		a.noWrite = noW;
		a.noRead = noR;
		return a;
	endfunction

	// Class flags: user rw, group r only, other none
	function automatic accModeT flagsAcc(krModeE mode);
		return mkAcc(ownerId, 3'b000, 3'b001, 3'b011, mode, 1'b0, 1'b0, 1'b0);
	endfunction

	function automatic excCodeE modelCode(accModeT acc, logic [63:0] ring, logic [4:0] op,
			logic [63:0] st);
		vugidT      id;
		logic       anyGrp;
		logic       anyUsr;
		logic       unpriv;
		logic       canR;
		logic       canW;
		logic [2:0] fl;
		unpriv = acc.noUser && !st[30];
		if (op[3] && (acc.noRead || unpriv))	// Base rules first, read wins
			return excReadFault;
		if (op[4] && (acc.noWrite || unpriv))
			return excWriteFault;
		if (ring[15:0] == 16'h0)	// Keyring off
			return excNone;
		anyGrp = 1'b0;
		anyUsr = 1'b0;
		for (int s = 0; s < numKeySlots; s++) begin
			id = ring[16*s +: 16];
			if (id != 16'h0 && id.group == acc.owner.group) begin
				anyGrp = 1'b1;
				anyUsr = anyUsr | (id.user == acc.owner.user);
			end
		end
		fl = anyUsr ? acc.userFl : (anyGrp ? acc.groupFl : acc.otherFl);
		canR = !op[3] || fl[0];
		canW = !op[4] || fl[1];
		case (acc.krMode)
			krLocked:      return op[3] ? excReadFault : (op[4] ? excWriteFault : excNone);
			krFlags:       return !canR ? excReadFault : (!canW ? excWriteFault : excNone);
			krFlagsStrict: return (canR && canW) ? excNone : excKeyDeny;
			default:       return excKeyDeny;
		endcase
	endfunction

	function automatic vugidT pickId(vugidT owner);
		case ($urandom_range(0, 3))
			0:       return 16'h0;
			1:       return owner;
			2:       return {owner.group, 10'($urandom)};
			default: return 16'($urandom);
		endcase
	endfunction

	task automatic addVec(accModeT acc, logic [63:0] ring, logic [4:0] op, logic [63:0] st,
			excCodeE exp);
		vecTable.push_back({acc, ring, op, st, exp});
	endtask

	task automatic buildTable();
		// Base denials, keyring off
		addVec(mkAcc(ownerId, 7, 7, 7, krFlags, 0, 1, 0), 64'h0, opW, stUser, excWriteFault);
		addVec(mkAcc(ownerId, 7, 7, 7, krFlags, 0, 0, 1), 64'h0, opR, stUser, excReadFault);
		addVec(mkAcc(ownerId, 7, 7, 7, krFlags, 1, 0, 0), 64'h0, opR, stUser, excReadFault);
		addVec(mkAcc(ownerId, 7, 7, 7, krFlags, 1, 0, 0), 64'h0, opW, stUser, excWriteFault);
		addVec(mkAcc(ownerId, 7, 7, 7, krFlags, 1, 0, 0), 64'h0, opRW, stSuper, excNone);
		// Class selection
		addVec(flagsAcc(krFlags), {48'h0, ownerId}, opRW, stUser, excNone);
		addVec(flagsAcc(krFlags), {48'h0, grpId}, opR, stUser, excNone);
		addVec(flagsAcc(krFlags), {48'h0, grpId}, opW, stUser, excWriteFault);
		addVec(flagsAcc(krFlags), {48'h0, otherId}, opR, stUser, excReadFault);
		addVec(flagsAcc(krFlags), {48'h0, otherId}, opW, stUser, excWriteFault);
		// Keyring modes
		addVec(flagsAcc(krLocked), {48'h0, ownerId}, opR, stUser, excReadFault);
		addVec(flagsAcc(krLocked), {48'h0, ownerId}, opW, stUser, excWriteFault);
		addVec(flagsAcc(krLocked), {48'h0, ownerId}, opNone, stUser, excNone);
		addVec(flagsAcc(krDenyAll), {48'h0, ownerId}, opNone, stUser, excKeyDeny);
		addVec(flagsAcc(krModeE'(3'd5)), {48'h0, ownerId}, opR, stUser, excKeyDeny);
		addVec(flagsAcc(krModeE'(3'd7)), {48'h0, ownerId}, opW, stUser, excKeyDeny);
		addVec(flagsAcc(krFlagsStrict), {48'h0, grpId}, opW, stUser, excKeyDeny);
		addVec(flagsAcc(krFlagsStrict), {48'h0, grpId}, opR, stUser, excNone);
		addVec(flagsAcc(krFlagsStrict), {48'h0, otherId}, opR, stUser, excKeyDeny);
		// Slot rules
		addVec(flagsAcc(krFlags), {16'h0, ownerId, 16'h0, otherId}, opRW, stUser, excNone);
		addVec(flagsAcc(krFlags), {32'h0, grpId, otherId}, opR, stUser, excNone);
		addVec(flagsAcc(krFlags), {grpId, 32'h0, otherId}, opR, stUser, excNone);
		addVec(flagsAcc(krFlags), {48'h0, swapId}, opR, stUser, excReadFault);
		addVec(mkAcc(16'h0, 0, 3, 3, krFlags, 0, 0, 0), {48'h0, otherId}, opR, stUser,
			excReadFault);	// Empty slots equal the zero owner
		// Priority
		addVec(mkAcc(ownerId, 7, 7, 7, krDenyAll, 0, 1, 0), {48'h0, ownerId}, opW, stUser,
			excWriteFault);
		addVec(mkAcc(ownerId, 7, 7, 7, krFlags, 0, 1, 1), {48'h0, ownerId}, opRW, stUser,
			excReadFault);
		addVec(flagsAcc(krLocked), {48'h0, ownerId}, opRW, stUser, excReadFault);
		addVec(mkAcc(ownerId, 7, 7, 7, krDenyAll, 1, 0, 0), {48'h0, ownerId}, opR, stUser,
			excReadFault);
	endtask

	task automatic sendReq(accModeT acc, logic [63:0] ring, logic [4:0] op, logic [63:0] st,
			excCodeE exp);
		@(posedge clock);
		reqValid  <= 1'b1;
		tlbAcc    <= acc;
		keyring   <= ring;
		opm       <= op;
		statusReg <= st;
		expCodes.push_back(exp);
		expEdges.push_back(edgeCount + driveToResult);
	endtask

	task automatic idleCycle();
		@(posedge clock);
		reqValid <= 1'b0;
	endtask

	// Outputs sampled between edges
	always @(negedge clock) begin
		if (arstN && excValid) begin
			if (expCodes.size() == 0) begin
				$display("Result strobe at %0t with no request outstanding", $time);
				$display("SIMULATION FAILED");
				$fatal(1, "unexpected result");
			end else begin
				check(excCode, expCodes.pop_front(), "exception code");
				check(edgeCount, expEdges.pop_front(), "result latency");
				checked++;
			end
		end
	end

	initial begin
		accModeT     rAcc;
		logic [63:0] rRing;
		logic [4:0]  rOp;
		logic [63:0] rSt;
		int          waitCount;
		void'($urandom(32'h8a));
		reqValid  = 1'b0;
		tlbAcc    = '0;
		keyring   = '0;
		opm       = '0;
		statusReg = '0;
		arstN     = 1'b0;
		buildTable();
		repeat (10) @(posedge clock);
		arstN <= 1'b1;
		foreach (vecTable[i])	// Back to back
			sendReq(vecTable[i].acc, vecTable[i].ring, vecTable[i].op, vecTable[i].st,
				vecTable[i].exp);
		for (int n = 0; n < numRandom; n++) begin
			rAcc  = accModeT'($urandom);
			rRing = {pickId(rAcc.owner), pickId(rAcc.owner), pickId(rAcc.owner),
				pickId(rAcc.owner)};
			rOp   = 5'($urandom);
			rSt   = {$urandom, $urandom};
			if ($urandom_range(0, 4) == 0)
				idleCycle();
			sendReq(rAcc, rRing, rOp, rSt, modelCode(rAcc, rRing, rOp, rSt));
		end
		idleCycle();
		waitCount = 0;
		while (expCodes.size() != 0 && waitCount < 20) begin
			@(posedge clock);
			waitCount++;
		end
		if (expCodes.size() != 0) begin
			$display("Timed out waiting for %0d outstanding results", expCodes.size());
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end else if (u_dut.uProps.assertFails != 0) begin
			$display("%0d assertion failures reported", u_dut.uProps.assertFails);
			$display("SIMULATION FAILED");
			$fatal(1, "assertion failures");
		end else begin
			$display("Checked %0d results", checked);
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// File: filelist.f
mmuPkg.sv
keyringSlotMatch.sv
accessRequestStage.sv
accessRuleEval.sv
mmuAccessCheck.sv
mmuAccessCheck_properties.sv
tbMmuAccessCheck.sv
